//--- files.f
logic/hyper_pkg.sv
logic/ax_rr_arbiter.sv
logic/tf_builder.sv
logic/id_queue.sv
logic/resp_tagger.sv
logic/hyper_front.sv
testbench/hyper_front_assertions.sv
testbench/tb_hyper_front.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_hyper_front
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG) || ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/tb_hyper_front.sv
/*
 * Testbench for the HyperBus front end: random bus and PHY traffic from a fixed
 * seed, a cycle model of arbitration and ID queues, and checks on every port.
 */

`timescale 1ns/1ps

module tb_hyper_front
    import hyper_pkg::*;
();

    localparam int unsigned NUM_CHIPS = 2;
    localparam int unsigned ID_DEPTH  = 4;
    localparam logic [ADDR_W-1:0] CHIP_SIZE = 32'h0100_0000;

    logic clk;
    logic rst_n;
    ax_req_t ar, aw;
    logic ar_valid, aw_valid, ar_ready, aw_ready;
    tx_t w, tx;
    logic w_valid, w_ready, tx_valid, tx_ready;
    r_resp_t r_beat;
    logic r_valid, r_ready;
    b_resp_t b_resp;
    logic b_valid, b_ready;
    hyper_tf_t trans;
    logic [NUM_CHIPS-1:0] trans_cs;
    logic trans_valid, trans_ready;
    rx_t rx_beat;
    logic rx_valid, rx_ready;
    b_t phy_b;
    logic phy_b_valid, phy_b_ready;
    chip_rule_t [NUM_CHIPS-1:0] chip_rules;

    // reference model state
    logic [ID_W-1:0] rd_ids[$];
    logic [ID_W-1:0] wr_ids[$];
    int rd_beats[$];
    int wr_beats[$];
    int tx_count, w_left;
    logic prefer_wr, locked, lock_wr, last_wr;
    int unsigned fires, rd_fires, wr_fires, rd_done;
    logic ar_taken, aw_taken, w_taken, rx_taken, b_taken;

    // stimulus knobs
    int unsigned rd_rate, wr_rate, rdy_rate;
    logic rx_en, b_en, alt_check;

    hyper_front #(
        .NUM_CHIPS ( NUM_CHIPS ),
        .ID_DEPTH  ( ID_DEPTH  )
    ) hyper_front_inst (
        .clk_i (clk), .rst_n_i (rst_n),
        .ar_i (ar), .ar_valid_i (ar_valid), .ar_ready_o (ar_ready),
        .aw_i (aw), .aw_valid_i (aw_valid), .aw_ready_o (aw_ready),
        .w_i (w), .w_valid_i (w_valid), .w_ready_o (w_ready),
        .r_o (r_beat), .r_valid_o (r_valid), .r_ready_i (r_ready),
        .b_o (b_resp), .b_valid_o (b_valid), .b_ready_i (b_ready),
        .trans_o (trans), .trans_cs_o (trans_cs), .trans_valid_o (trans_valid),
        .trans_ready_i (trans_ready),
        .tx_o (tx), .tx_valid_o (tx_valid), .tx_ready_i (tx_ready),
        .rx_i (rx_beat), .rx_valid_i (rx_valid), .rx_ready_o (rx_ready),
        .b_i (phy_b), .b_valid_i (phy_b_valid), .b_ready_o (phy_b_ready),
        .chip_rules_i (chip_rules)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic value_error(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        stop_run();
    endtask

    // a quarter of addresses land in each chip, the rest anywhere
    function automatic logic [ADDR_W-1:0] random_addr();
        case ($urandom % 4)
            0: return $urandom % CHIP_SIZE;
            1: return 32'h8000_0000 + ($urandom % CHIP_SIZE);
            default: return $urandom;
        endcase
    endfunction

    function automatic ax_req_t random_req();
        ax_req_t req;
        req.addr  = random_addr();
        req.id    = ID_W'($urandom);
        req.len   = 8'($urandom % 4);
        req.burst = burst_e'(2'($urandom % 3));
        return req;
    endfunction

    function automatic logic [NUM_CHIPS-1:0] expect_cs(input logic [ADDR_W-1:0] addr);
        for (int i = 0; i < NUM_CHIPS; i++) begin
            if (addr >= chip_rules[i].start_addr && addr < chip_rules[i].end_addr) begin
                return NUM_CHIPS'(1) << i;
            end
        end
        return NUM_CHIPS'(1);
    endfunction

    function automatic logic idle();
        return !ar_valid && !aw_valid && !rx_valid && !phy_b_valid &&
               rd_ids.size() == 0 && wr_ids.size() == 0 && w_left == 0;
    endfunction

    task automatic drive_inputs();
        if (ar_taken) ar_valid = 1'b0;
        if (aw_taken) aw_valid = 1'b0;
        if (w_taken) w_valid = 1'b0;
        if (rx_taken) rx_valid = 1'b0;
        if (b_taken) phy_b_valid = 1'b0;
        {ar_taken, aw_taken, w_taken, rx_taken, b_taken} = '0;
        if (!ar_valid && ($urandom % 100) < rd_rate) begin
            ar = random_req();
            ar_valid = 1'b1;
        end
        if (!aw_valid && ($urandom % 100) < wr_rate) begin
            aw = random_req();
            aw_valid = 1'b1;
        end
        if (!w_valid && w_left > 0) begin
            w.data = DATA_W'($urandom);
            w.strb = 2'($urandom);
            w_valid = 1'b1;
        end
        // PHY returns read beats for the oldest accepted read
        if (!rx_valid && rx_en && rd_beats.size() > 0) begin
            rx_beat.data = DATA_W'($urandom);
            rx_beat.last = (rd_beats[0] == 1);
            rx_beat.error = ($urandom % 4 == 0);
            rx_valid = 1'b1;
        end
        // status with last only once all tx beats of the write arrived
        if (!phy_b_valid && b_en) begin
            if (wr_beats.size() > 0 && tx_count >= wr_beats[0]) begin
                phy_b.last = 1'b1;
                phy_b.error = ($urandom % 4 == 0);
                phy_b_valid = 1'b1;
            end else if ($urandom % 4 == 0) begin
                phy_b.last = 1'b0;
                phy_b.error = 1'($urandom);
                phy_b_valid = 1'b1;
            end
        end
        trans_ready = ($urandom % 100) < rdy_rate;
        tx_ready = ($urandom % 4) != 0;
        r_ready = ($urandom % 4) != 0;
        b_ready = ($urandom % 4) != 0;
    endtask

    task automatic check_transaction(input logic exp_valid, input logic sel_wr,
                                     input ax_req_t req);
        assert (trans_valid == exp_valid)
            else value_error($sformatf("trans_valid_o is %b, expected %b",
                                       trans_valid, exp_valid));
        assert (ar_ready == (exp_valid && !sel_wr && trans_ready) &&
                aw_ready == (exp_valid && sel_wr && trans_ready))
            else value_error($sformatf("ar_ready_o %b aw_ready_o %b, wrong grant",
                                       ar_ready, aw_ready));
        if (exp_valid) begin
            assert (trans.address == req.addr && trans.write == sel_wr)
                else value_error($sformatf("trans_o address %h write %b, expected %h %b",
                                           trans.address, trans.write, req.addr, sel_wr));
            assert (trans.burst == 9'(req.len) + 9'd1 &&
                    trans.burst_type == (req.burst == BURST_INCR) &&
                    trans.address_space == req.addr[ADDR_W-1])
                else value_error($sformatf("trans_o burst fields wrong for len %0d", req.len));
            assert ($onehot(trans_cs) && trans_cs == expect_cs(req.addr))
                else value_error($sformatf("trans_cs_o %b for address %h", trans_cs, req.addr));
        end
        assert (tx_valid == w_valid && w_ready == tx_ready && (!w_valid || tx == w))
            else value_error("w to tx pass-through mismatch");
    endtask

    task automatic check_responses();
        assert (r_valid == rx_valid && rx_ready == r_ready)
            else value_error("r_valid_o or rx_ready_o does not follow its source");
        if (rx_valid) begin
            assert (r_beat.id == rd_ids[0])
                else value_error($sformatf("r_o.id %h, expected %h", r_beat.id, rd_ids[0]));
            assert (r_beat.data == rx_beat.data && r_beat.last == rx_beat.last &&
                    r_beat.resp == (rx_beat.error ? RESP_SLVERR : RESP_OKAY))
                else value_error("r_o data, last or resp mismatch");
        end
        assert (b_valid == (phy_b_valid && phy_b.last) && phy_b_ready == b_ready)
            else value_error($sformatf("b_valid_o is %b for PHY status last %b",
                                       b_valid, phy_b.last));
        if (phy_b_valid && phy_b.last) begin
            assert (b_resp.id == wr_ids[0] &&
                    b_resp.resp == (phy_b.error ? RESP_SLVERR : RESP_OKAY))
                else value_error($sformatf("b_o id %h resp %0d, expected id %h",
                                           b_resp.id, b_resp.resp, wr_ids[0]));
        end
        assert (hyper_front_inst.ax_rr_arbiter_inst.hyper_front_assertions_inst.fail_count == 0)
            else value_error("bound arbiter protocol assertion failed");
    endtask

    // one clock cycle: drive, check, then advance the model past the rising edge
    task automatic step();
        logic rd_req;
        logic wr_req;
        logic sel_wr;
        logic exp_valid;
        ax_req_t exp_req;
        @(negedge clk);
        drive_inputs();
        #2;
        rd_req = ar_valid && (rd_ids.size() < ID_DEPTH);
        wr_req = aw_valid && (wr_ids.size() < ID_DEPTH);
        if (locked) begin
            sel_wr = lock_wr;
        end else if (rd_req && wr_req) begin
            sel_wr = prefer_wr;
        end else begin
            sel_wr = wr_req;
        end
        exp_valid = sel_wr ? wr_req : rd_req;
        exp_req = sel_wr ? aw : ar;
        check_transaction(exp_valid, sel_wr, exp_req);
        check_responses();
        // accepted requests as seen on the DUT handshakes
        if (ar_valid && ar_ready) rd_fires++;
        if (aw_valid && aw_ready) wr_fires++;
        if (exp_valid && trans_ready) begin
            if (fires == 0) begin
                assert (ar_ready && !trans.write)
                    else value_error("first transaction after reset is not a read");
            end
            if (alt_check && rd_req && wr_req && fires > 0) begin
                assert (trans.write != last_wr)
                    else value_error("read and write did not alternate");
            end
            fires++;
            last_wr = trans.write;
            prefer_wr = !sel_wr;
            if (sel_wr) begin
                wr_ids.push_back(aw.id);
                wr_beats.push_back(int'(aw.len) + 1);
                w_left += int'(aw.len) + 1;
                aw_taken = 1'b1;
            end else begin
                rd_ids.push_back(ar.id);
                rd_beats.push_back(int'(ar.len) + 1);
                ar_taken = 1'b1;
            end
        end
        locked = exp_valid && !trans_ready;
        if (locked) lock_wr = sel_wr;
        if (w_valid && tx_ready) begin
            tx_count++;
            w_left--;
            w_taken = 1'b1;
        end
        if (rx_valid && r_ready) begin
            rx_taken = 1'b1;
            rd_beats[0] = rd_beats[0] - 1;
            if (rx_beat.last) begin
                void'(rd_beats.pop_front());
                void'(rd_ids.pop_front());
                rd_done++;
            end
        end
        if (phy_b_valid && b_ready) begin
            b_taken = 1'b1;
            if (phy_b.last) begin
                tx_count -= wr_beats.pop_front();
                void'(wr_ids.pop_front());
            end
        end
    endtask

    initial begin
        int unsigned n;
        int unsigned rd_mark;
        int unsigned wr_mark;
        int unsigned done_mark;
        void'($urandom(14));
        rst_n = 1'b0;
        {ar, aw, w, rx_beat, phy_b} = '0;
        {ar_valid, aw_valid, w_valid, rx_valid, phy_b_valid} = '0;
        {r_ready, b_ready, trans_ready, tx_ready} = '0;
        chip_rules[0] = '{start_addr: 32'h0000_0000, end_addr: CHIP_SIZE};
        chip_rules[1] = '{start_addr: 32'h8000_0000, end_addr: 32'h8000_0000 + CHIP_SIZE};
        {prefer_wr, locked, lock_wr, last_wr, alt_check} = '0;
        {ar_taken, aw_taken, w_taken, rx_taken, b_taken} = '0;
        {tx_count, w_left, fires, rd_fires, wr_fires, rd_done} = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #2;
        assert (!trans_valid && !r_valid && !b_valid)
            else value_error("valid outputs high right after reset");

        // both channels always pending, port always ready
        {rd_rate, wr_rate, rdy_rate} = {32'd100, 32'd100, 32'd100};
        {rx_en, b_en, alt_check} = 3'b111;
        repeat (60) step();
        alt_check = 1'b0;

        // mixed random traffic with stalls
        {rd_rate, wr_rate, rdy_rate} = {32'd50, 32'd50, 32'd70};
        repeat (3000) step();

        {rd_rate, wr_rate, rdy_rate} = {32'd0, 32'd0, 32'd100};
        n = 0;
        while (!idle() && n < 2000) begin
            step();
            n++;
        end
        if (!idle()) begin
            $display("timeout: outstanding traffic did not drain");
            stop_run();
        end

        // fill the read ID queue with no read data coming back
        {rd_rate, wr_rate, rx_en} = {32'd100, 32'd100, 1'b0};
        n = 0;
        while (rd_ids.size() < ID_DEPTH && n < 200) begin
            step();
            n++;
        end
        if (rd_ids.size() < ID_DEPTH) begin
            $display("timeout: read ID queue never filled");
            stop_run();
        end
        wr_mark = wr_fires;
        repeat (20) begin
            step();
            assert (!ar_ready) else value_error("read accepted with a full read ID queue");
        end
        assert (wr_fires > wr_mark) else value_error("writes stalled behind a full read queue");

        // one finished read burst frees a slot
        rd_mark = rd_fires;
        done_mark = rd_done;
        rx_en = 1'b1;
        n = 0;
        while (rd_fires == rd_mark && n < 200) begin
            step();
            n++;
        end
        if (rd_fires == rd_mark) begin
            $display("timeout: no read accepted after a read burst completed");
            stop_run();
        end
        assert (rd_done > done_mark) else value_error("read accepted before any last beat");

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- testbench/hyper_front_assertions.sv
/*
 * Concurrent checks on the ar/aw arbiter, bound into ax_rr_arbiter.
 * Failures raise $error and count up for the testbench to see.
 */

`timescale 1ns/1ps

module hyper_front_assertions
    import hyper_pkg::*;
(
    input logic    clk_i,
    input logic    rst_n_i,
    input logic    rd_ready_o,
    input logic    wr_ready_o,
    input ax_req_t req_o,
    input logic    write_o,
    input logic    valid_o,
    input logic    ready_i
);

    int unsigned fail_count = 0;

    // a stalled offer holds its request and direction
    stall_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (valid_o && !ready_i) |=> (valid_o && $stable(req_o) && $stable(write_o)))
        else begin
            fail_count++;
            $error("stalled arbiter request changed");
        end

    // only one side granted
    single_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(rd_ready_o && wr_ready_o))
        else begin
            fail_count++;
            $error("read and write ready high together");
        end

endmodule

bind ax_rr_arbiter hyper_front_assertions hyper_front_assertions_inst (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .rd_ready_o ( rd_ready_o ),
    .wr_ready_o ( wr_ready_o ),
    .req_o      ( req_o      ),
    .write_o    ( write_o    ),
    .valid_o    ( valid_o    ),
    .ready_i    ( ready_i    )
);

//--- logic/hyper_front.sv
/*
 * AXI-side front end of the HyperBus controller.
 * Arbitrates ar/aw onto the PHY transaction port and tags responses with IDs.
 */

`timescale 1ns/1ps

module hyper_front
    import hyper_pkg::*;
#(
    parameter int unsigned NUM_CHIPS = 2,
    parameter int unsigned ID_DEPTH  = 4
) (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    // bus side
    input  ax_req_t                    ar_i,
    input  logic                       ar_valid_i,
    output logic                       ar_ready_o,
    input  ax_req_t                    aw_i,
    input  logic                       aw_valid_i,
    output logic                       aw_ready_o,
    input  tx_t                        w_i,
    input  logic                       w_valid_i,
    output logic                       w_ready_o,
    output r_resp_t                    r_o,
    output logic                       r_valid_o,
    input  logic                       r_ready_i,
    output b_resp_t                    b_o,
    output logic                       b_valid_o,
    input  logic                       b_ready_i,
    // PHY side
    output hyper_tf_t                  trans_o,
    output logic [NUM_CHIPS-1:0]       trans_cs_o,
    output logic                       trans_valid_o,
    input  logic                       trans_ready_i,
    output tx_t                        tx_o,
    output logic                       tx_valid_o,
    input  logic                       tx_ready_i,
    input  rx_t                        rx_i,
    input  logic                       rx_valid_i,
    output logic                       rx_ready_o,
    input  b_t                         b_i,
    input  logic                       b_valid_i,
    output logic                       b_ready_o,
    input  chip_rule_t [NUM_CHIPS-1:0] chip_rules_i
);

    ax_req_t ax_req;
    logic    ax_write;
    logic    rd_full;
    logic    wr_full;

    // w goes straight to the PHY
    assign tx_o       = w_i;
    assign tx_valid_o = w_valid_i;
    assign w_ready_o  = tx_ready_i;

    ax_rr_arbiter ax_rr_arbiter_inst (
        .clk_i      ( clk_i          ),
        .rst_n_i    ( rst_n_i        ),
        .rd_i       ( ar_i           ),
        .wr_i       ( aw_i           ),
        .rd_valid_i ( ar_valid_i     ),
        .wr_valid_i ( aw_valid_i     ),
        .rd_block_i ( rd_full        ),
        .wr_block_i ( wr_full        ),
        .rd_ready_o ( ar_ready_o     ),
        .wr_ready_o ( aw_ready_o     ),
        .req_o      ( ax_req         ),
        .write_o    ( ax_write       ),
        .valid_o    ( trans_valid_o  ),
        .ready_i    ( trans_ready_i  )
    );

    tf_builder #(
        .NUM_CHIPS    ( NUM_CHIPS    )
    ) tf_builder_inst (
        .req_i        ( ax_req       ),
        .write_i      ( ax_write     ),
        .chip_rules_i ( chip_rules_i ),
        .trans_o      ( trans_o      ),
        .cs_o         ( trans_cs_o   )
    );

    resp_tagger #(
        .ID_DEPTH      ( ID_DEPTH                       )
    ) resp_tagger_inst (
        .clk_i         ( clk_i                          ),
        .rst_n_i       ( rst_n_i                        ),
        .issue_valid_i ( trans_valid_o & trans_ready_i  ),
        .issue_write_i ( ax_write                       ),
        .issue_id_i    ( ax_req.id                      ),
        .rx_i          ( rx_i                           ),
        .rx_valid_i    ( rx_valid_i                     ),
        .rx_ready_o    ( rx_ready_o                     ),
        .r_o           ( r_o                            ),
        .r_valid_o     ( r_valid_o                      ),
        .r_ready_i     ( r_ready_i                      ),
        .b_i           ( b_i                            ),
        .b_valid_i     ( b_valid_i                      ),
        .b_ready_o     ( b_ready_o                      ),
        .b_o           ( b_o                            ),
        .b_valid_o     ( b_valid_o                      ),
        .b_ready_i     ( b_ready_i                      ),
        .rd_full_o     ( rd_full                        ),
        .wr_full_o     ( wr_full                        )
    );

endmodule

//--- logic/resp_tagger.sv
/*
 * Tags PHY read beats and write status with the ID of the oldest outstanding
 * transaction and an AXI response code; one ID queue per direction.
 */

`timescale 1ns/1ps

module resp_tagger
    import hyper_pkg::*;
#(
    parameter int unsigned ID_DEPTH = 4
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            issue_valid_i,
    input  logic            issue_write_i,
    input  logic [ID_W-1:0] issue_id_i,
    input  rx_t             rx_i,
    input  logic            rx_valid_i,
    output logic            rx_ready_o,
    output r_resp_t         r_o,
    output logic            r_valid_o,
    input  logic            r_ready_i,
    input  b_t              b_i,
    input  logic            b_valid_i,
    output logic            b_ready_o,
    output b_resp_t         b_o,
    output logic            b_valid_o,
    input  logic            b_ready_i,
    output logic            rd_full_o,
    output logic            wr_full_o
);

    logic [ID_W-1:0] rd_head;
    logic [ID_W-1:0] wr_head;
    logic            rd_pop;
    logic            wr_pop;

    // read beats pass through, ID changes only after last
    assign r_valid_o  = rx_valid_i;
    assign rx_ready_o = r_ready_i;
    assign r_o.id     = rd_head;
    assign r_o.data   = rx_i.data;
    assign r_o.last   = rx_i.last;
    assign r_o.resp   = rx_i.error ? RESP_SLVERR : RESP_OKAY;
    assign rd_pop     = rx_valid_i & r_ready_i & rx_i.last;

    // non-last status beats are accepted and dropped
    assign b_valid_o = b_valid_i & b_i.last;
    assign b_ready_o = b_ready_i;
    assign b_o.id    = wr_head;
    assign b_o.resp  = b_i.error ? RESP_SLVERR : RESP_OKAY;
    assign wr_pop    = b_valid_i & b_ready_i & b_i.last;

    id_queue #(
        .DEPTH   ( ID_DEPTH                        )
    ) rd_queue_inst (
        .clk_i   ( clk_i                           ),
        .rst_n_i ( rst_n_i                         ),
        .push_i  ( issue_valid_i & ~issue_write_i  ),
        .id_i    ( issue_id_i                      ),
        .pop_i   ( rd_pop                          ),
        .head_o  ( rd_head                         ),
        .full_o  ( rd_full_o                       ),
        .empty_o (                                 )
    );

    id_queue #(
        .DEPTH   ( ID_DEPTH                        )
    ) wr_queue_inst (
        .clk_i   ( clk_i                           ),
        .rst_n_i ( rst_n_i                         ),
        .push_i  ( issue_valid_i & issue_write_i   ),
        .id_i    ( issue_id_i                      ),
        .pop_i   ( wr_pop                          ),
        .head_o  ( wr_head                         ),
        .full_o  ( wr_full_o                       ),
        .empty_o (                                 )
    );

endmodule

//--- logic/id_queue.sv
/*
 * In-order FIFO of outstanding AXI IDs for one direction.
 * Push on issue, pop on the last response beat; head is the oldest ID.
 */

`timescale 1ns/1ps

module id_queue
    import hyper_pkg::*;
#(
    parameter int unsigned DEPTH = 4
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            push_i,
    input  logic [ID_W-1:0] id_i,
    input  logic            pop_i,
    output logic [ID_W-1:0] head_o,
    output logic            full_o,
    output logic            empty_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    logic [ID_W-1:0]  mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);
    assign head_o  = mem[rd_ptr_q];

    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr_q] <= id_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // simultaneous push and pop cancel out
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

//--- logic/tf_builder.sv
/*
 * Builds the PHY transaction descriptor from the granted address request
 * and decodes the one-hot chip select from the chip address table.
 */

`timescale 1ns/1ps

module tf_builder
    import hyper_pkg::*;
#(
    parameter int unsigned NUM_CHIPS = 2
) (
    input  ax_req_t                     req_i,
    input  logic                        write_i,
    input  chip_rule_t [NUM_CHIPS-1:0]  chip_rules_i,
    output hyper_tf_t                   trans_o,
    output logic [NUM_CHIPS-1:0]        cs_o
);

    logic hit;

    assign trans_o.address       = req_i.addr;
    assign trans_o.write         = write_i;
    // AXI len counts beats minus one
    assign trans_o.burst         = {1'b0, req_i.len} + 9'd1;
    assign trans_o.burst_type    = (req_i.burst == BURST_INCR);
    assign trans_o.address_space = req_i.addr[ADDR_W-1];

    // first matching rule wins
    always_comb begin
        cs_o = '0;
        hit  = 1'b0;
        for (int i = 0; i < NUM_CHIPS; i++) begin
            if (!hit &&
                req_i.addr >= chip_rules_i[i].start_addr &&
                req_i.addr <  chip_rules_i[i].end_addr) begin
                cs_o[i] = 1'b1;
                hit     = 1'b1;
            end
        end
        // unmapped addresses go to chip 0
        if (!hit) begin
            cs_o[0] = 1'b1;
        end
    end

endmodule

//--- logic/ax_rr_arbiter.sv
/*
 * Two-way round-robin arbiter between the ar and aw channels.
 * Holds its choice while the transaction port stalls, so the output stays stable.
 */

`timescale 1ns/1ps

module ax_rr_arbiter
    import hyper_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  ax_req_t rd_i,
    input  ax_req_t wr_i,
    input  logic    rd_valid_i,
    input  logic    wr_valid_i,
    input  logic    rd_block_i,
    input  logic    wr_block_i,
    output logic    rd_ready_o,
    output logic    wr_ready_o,
    output ax_req_t req_o,
    output logic    write_o,
    output logic    valid_o,
    input  logic    ready_i
);

    logic rd_req;
    logic wr_req;
    logic sel_wr;
    logic prefer_wr_q;
    logic locked_q;
    logic lock_wr_q;

    // a full ID queue hides its side from arbitration
    assign rd_req = rd_valid_i & ~rd_block_i;
    assign wr_req = wr_valid_i & ~wr_block_i;

    always_comb begin
        if (locked_q) begin
            sel_wr = lock_wr_q;
        end else if (rd_req && wr_req) begin
            sel_wr = prefer_wr_q;
        end else begin
            sel_wr = wr_req;
        end
    end

    assign req_o   = sel_wr ? wr_i : rd_i;
    assign valid_o = sel_wr ? wr_req : rd_req;
    assign write_o = sel_wr;

    assign rd_ready_o = ready_i & ~sel_wr & rd_req;
    assign wr_ready_o = ready_i & sel_wr & wr_req;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prefer_wr_q <= 1'b0;
            locked_q    <= 1'b0;
            lock_wr_q   <= 1'b0;
        end else begin
            // stalled offer keeps the grant until it is taken
            locked_q <= valid_o & ~ready_i;
            if (valid_o && !ready_i) begin
                lock_wr_q <= sel_wr;
            end
            // on a transfer, the other direction goes first next time
            if (valid_o && ready_i) begin
                prefer_wr_q <= ~sel_wr;
            end
        end
    end

endmodule

//--- logic/hyper_pkg.sv
/*
 * Shared widths, AXI enums and channel structs for the HyperBus front end.
 * Imported by every RTL module of the controller front end.
 */

package hyper_pkg;

    localparam int unsigned ADDR_W = 32;
    localparam int unsigned ID_W   = 4;
    localparam int unsigned DATA_W = 16;

    // AXI burst encoding
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } burst_e;

    // only the two codes this controller can return
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

    // address request, same layout for ar and aw
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [ID_W-1:0]   id;
        logic [7:0]        len;
        burst_e            burst;
    } ax_req_t;

    // transaction descriptor for the PHY
    typedef struct packed {
        logic [ADDR_W-1:0] address;
        logic              write;
        logic [8:0]        burst;
        logic              burst_type;    // 1 = incrementing
        logic              address_space;
    } hyper_tf_t;

    typedef struct packed {
        logic [DATA_W-1:0]   data;
        logic [DATA_W/8-1:0] strb;
    } tx_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
        logic              error;
    } rx_t;

    typedef struct packed {
        logic last;
        logic error;
    } b_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic              last;
        resp_e             resp;
    } r_resp_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        resp_e           resp;
    } b_resp_t;

    // end_addr is exclusive
    typedef struct packed {
        logic [ADDR_W-1:0] start_addr;
        logic [ADDR_W-1:0] end_addr;
    } chip_rule_t;

endpackage
